/* hw/sb_pkg.sv */
// shared types, encodings and latencies of the scoreboard issue core
// imported by every RTL module of the subsystem
`default_nettype none

package sb_pkg;

    // data word and raw instruction word
    typedef logic [15:0] word_t;
    // op 15:14, rd 13:11, rs1 10:8, rs2 7:5, imm 4:0
    typedef logic [15:0] instr_t;
    typedef logic [2:0]  reg_t;
    typedef logic [4:0]  imm_t;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_MUL = 2'd1,
        OP_LD  = 2'd2,
        OP_ST  = 2'd3
    } opcode_t;

    // unit index doubles as the row index of the status table
    typedef logic [1:0] fu_idx_t;
    localparam fu_idx_t FU_ALU = 2'd0;
    localparam fu_idx_t FU_MUL = 2'd1;
    localparam fu_idx_t FU_MEM = 2'd2;

    localparam int NUM_FU   = 3;
    localparam int NUM_REGS = 8;

    typedef logic [NUM_FU-1:0] fu_vec_t;

    // producer tag is unit index + 1, zero means the value is in the regfile
    typedef logic [1:0] tag_t;
    // rank among occupied rows, higher is older
    typedef logic [1:0] age_t;

    typedef enum logic [1:0] {
        EMPTY,
        WAIT,
        RDY,
        EX
    } row_state_e;

    // cycles from iss_en to result
    localparam int MUL_LAT   = 3;
    localparam int MEM_LAT   = 2;
    localparam int MEM_WORDS = 16;
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    // drops a tag whose producer reports done this cycle
    function automatic tag_t drop_done(tag_t t, fu_vec_t done);
        tag_t r;
        r = t;
        for (int k = 0; k < NUM_FU; k++) begin
            if (done[k] && t == tag_t'(k + 1)) begin
                r = '0;
            end
        end
        return r;
    endfunction

endpackage

`default_nettype wire

/* hw/regfile.sv */
// architectural register file, two combinational reads and one write per edge
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic          CLK,
    input  logic          nRST,
    input  logic          wen,
    input  sb_pkg::reg_t  wsel,
    input  sb_pkg::word_t wdata,
    input  sb_pkg::reg_t  rsel1,
    input  sb_pkg::reg_t  rsel2,
    output sb_pkg::word_t rdat1,
    output sb_pkg::word_t rdat2
);

    import sb_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wen) begin
            regs[wsel] <= wdata;
        end
    end

    // no write bypass, issue reads a cycle after write-back
    assign rdat1 = regs[rsel1];
    assign rdat2 = regs[rsel2];

endmodule

`default_nettype wire

/* hw/fust.sv */
// functional unit status table, one row per unit, written by dispatch
// and read by the issue stage; producer tags clear on write-back
`timescale 1ns/1ps
`default_nettype none

module fust (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            disp_en,
    input  sb_pkg::fu_idx_t disp_fu,
    input  sb_pkg::opcode_t disp_op,
    input  sb_pkg::reg_t    disp_rd,
    input  sb_pkg::reg_t    disp_rs1,
    input  sb_pkg::reg_t    disp_rs2,
    input  sb_pkg::imm_t    disp_imm,
    input  sb_pkg::tag_t    disp_t1,
    input  sb_pkg::tag_t    disp_t2,
    input  sb_pkg::fu_vec_t wb_done,
    output sb_pkg::opcode_t row_op  [sb_pkg::NUM_FU],
    output sb_pkg::reg_t    row_rd  [sb_pkg::NUM_FU],
    output sb_pkg::reg_t    row_rs1 [sb_pkg::NUM_FU],
    output sb_pkg::reg_t    row_rs2 [sb_pkg::NUM_FU],
    output sb_pkg::imm_t    row_imm [sb_pkg::NUM_FU],
    output sb_pkg::fu_vec_t row_ready
);

    import sb_pkg::*;

    tag_t t1 [NUM_FU];
    tag_t t2 [NUM_FU];

    // tags: new row from dispatch, else drop producers that finish
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_FU; i++) begin
                t1[i] <= '0;
                t2[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_FU; i++) begin
                if (disp_en && disp_fu == fu_idx_t'(i)) begin
                    t1[i] <= disp_t1;
                    t2[i] <= disp_t2;
                end else begin
                    t1[i] <= drop_done(t1[i], wb_done);
                    t2[i] <= drop_done(t2[i], wb_done);
                end
            end
        end
    end

    // operation fields of the row
    always_ff @(posedge CLK) begin
        if (disp_en) begin
            row_op[disp_fu]  <= disp_op;
            row_rd[disp_fu]  <= disp_rd;
            row_rs1[disp_fu] <= disp_rs1;
            row_rs2[disp_fu] <= disp_rs2;
            row_imm[disp_fu] <= disp_imm;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            row_ready[i] = (t1[i] == '0) && (t2[i] == '0);
        end
    end

endmodule

`default_nettype wire

/* hw/dispatch.sv */
// in-order dispatch: decodes instruction words, tracks pending producers and
// per-unit credits, and writes one status row per accepted word
`timescale 1ns/1ps
`default_nettype none

module dispatch (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            in_valid,
    input  sb_pkg::instr_t  in_instr,
    output logic            in_ready,
    output logic            disp_en,
    output sb_pkg::fu_idx_t disp_fu,
    output sb_pkg::opcode_t disp_op,
    output sb_pkg::reg_t    disp_rd,
    output sb_pkg::reg_t    disp_rs1,
    output sb_pkg::reg_t    disp_rs2,
    output sb_pkg::imm_t    disp_imm,
    output sb_pkg::tag_t    disp_t1,
    output sb_pkg::tag_t    disp_t2,
    input  sb_pkg::fu_vec_t credit_ret,
    input  sb_pkg::fu_vec_t wb_done
);

    import sb_pkg::*;

    // one credit per unit row
    fu_vec_t credit;
    fu_vec_t sent;
    // register status, pending producer tag per register
    tag_t    rstat     [NUM_REGS];
    tag_t    rstat_cur [NUM_REGS];
    logic    writes_rd;

    always_comb begin
        disp_op  = opcode_t'(in_instr[15:14]);
        disp_rd  = in_instr[13:11];
        disp_rs1 = in_instr[10:8];
        disp_rs2 = in_instr[7:5];
        disp_imm = in_instr[4:0];
        case (disp_op)
            OP_ADD:  disp_fu = FU_ALU;
            OP_MUL:  disp_fu = FU_MUL;
            default: disp_fu = FU_MEM;
        endcase
        // stores have no destination
        writes_rd = (disp_op != OP_ST);
    end

    // status seen this cycle, producers finishing now already dropped
    always_comb begin
        for (int r = 0; r < NUM_REGS; r++) begin
            rstat_cur[r] = drop_done(rstat[r], wb_done);
        end
    end

    always_comb begin
        disp_t1 = rstat_cur[disp_rs1];
        // loads never read rs2
        disp_t2 = (disp_op == OP_LD) ? '0 : rstat_cur[disp_rs2];
        // stall on no credit or on WAW, registered state only
        in_ready = credit[disp_fu] && !(writes_rd && rstat[disp_rd] != '0);
        disp_en  = in_valid && in_ready;
        sent     = disp_en ? (fu_vec_t'(1) << disp_fu) : '0;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            credit <= '1;
            for (int r = 0; r < NUM_REGS; r++) begin
                rstat[r] <= '0;
            end
        end else begin
            credit <= (credit & ~sent) | credit_ret;
            for (int r = 0; r < NUM_REGS; r++) begin
                rstat[r] <= rstat_cur[r];
            end
            if (disp_en && writes_rd) begin
                rstat[disp_rd] <= tag_t'(disp_fu) + 2'd1;
            end
        end
    end

    // issue only frees a row that dispatch filled
    a_credit_ret: assert property (@(posedge CLK) disable iff (!nRST)
        (credit_ret & credit) == '0);

endmodule

`default_nettype wire

/* hw/issue.sv */
// issue stage: per-row state machine, age ranking, oldest-first selection
// with a WAR check, and operand read for the selected row
`timescale 1ns/1ps
`default_nettype none

module issue (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            disp_en,
    input  sb_pkg::fu_idx_t disp_fu,
    input  sb_pkg::opcode_t disp_op,
    input  sb_pkg::reg_t    disp_rd,
    input  sb_pkg::reg_t    disp_rs1,
    input  sb_pkg::reg_t    disp_rs2,
    input  sb_pkg::imm_t    disp_imm,
    input  sb_pkg::tag_t    disp_t1,
    input  sb_pkg::tag_t    disp_t2,
    output sb_pkg::fu_vec_t credit_ret,
    input  sb_pkg::fu_vec_t wb_done,
    input  logic            wb_en,
    input  sb_pkg::reg_t    wb_reg,
    input  sb_pkg::word_t   wb_data,
    output sb_pkg::fu_vec_t iss_en,
    output sb_pkg::opcode_t iss_op,
    output sb_pkg::reg_t    iss_rd,
    output sb_pkg::word_t   iss_a,
    output sb_pkg::word_t   iss_b,
    output sb_pkg::imm_t    iss_imm
);

    import sb_pkg::*;

    opcode_t    row_op  [NUM_FU];
    reg_t       row_rd  [NUM_FU];
    reg_t       row_rs1 [NUM_FU];
    reg_t       row_rs2 [NUM_FU];
    imm_t       row_imm [NUM_FU];
    fu_vec_t    row_ready;
    row_state_e state     [NUM_FU];
    row_state_e state_nxt [NUM_FU];
    age_t       age       [NUM_FU];
    age_t       age_nxt   [NUM_FU];
    // rows that have not read their operands yet
    fu_vec_t    pending;
    fu_vec_t    war_block;
    fu_vec_t    eligible;
    fu_idx_t    sel;
    logic       sel_valid;

    fust i_fust (
        .CLK, .nRST, .disp_en, .disp_fu, .disp_op, .disp_rd, .disp_rs1, .disp_rs2,
        .disp_imm, .disp_t1, .disp_t2, .wb_done,
        .row_op, .row_rd, .row_rs1, .row_rs2, .row_imm, .row_ready
    );

    regfile i_rf (
        .CLK, .nRST,
        .wen   (wb_en),
        .wsel  (wb_reg),
        .wdata (wb_data),
        .rsel1 (row_rs1[sel]),
        .rsel2 (row_rs2[sel]),
        .rdat1 (iss_a),
        .rdat2 (iss_b)
    );

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            pending[i] = (state[i] == WAIT) || (state[i] == RDY);
        end
        // WAR: hold a writer while an older row still has to read its rd
        for (int i = 0; i < NUM_FU; i++) begin
            war_block[i] = 1'b0;
            for (int j = 0; j < NUM_FU; j++) begin
                if (j != i && pending[j] && age[j] > age[i] && row_op[i] != OP_ST &&
                    (row_rs1[j] == row_rd[i] ||
                     (row_op[j] != OP_LD && row_rs2[j] == row_rd[i]))) begin
                    war_block[i] = 1'b1;
                end
            end
            eligible[i] = ((state[i] == WAIT && row_ready[i]) || state[i] == RDY) &&
                          !war_block[i];
        end
        // oldest first, strict compare keeps ties on the lower index
        sel       = FU_ALU;
        sel_valid = 1'b0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (eligible[i] && (!sel_valid || age[i] > age[sel])) begin
                sel       = fu_idx_t'(i);
                sel_valid = 1'b1;
            end
        end
        iss_en  = sel_valid ? (fu_vec_t'(1) << sel) : '0;
        iss_op  = row_op[sel];
        iss_rd  = row_rd[sel];
        iss_imm = row_imm[sel];
    end

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            state_nxt[i] = state[i];
            case (state[i])
                EMPTY: if (disp_en && disp_fu == fu_idx_t'(i)) state_nxt[i] = WAIT;
                WAIT: begin
                    if (iss_en[i]) begin
                        state_nxt[i] = EX;
                    end else if (row_ready[i]) begin
                        state_nxt[i] = RDY;
                    end
                end
                RDY:   if (iss_en[i]) state_nxt[i] = EX;
                EX:    if (wb_done[i]) state_nxt[i] = EMPTY;
                default: state_nxt[i] = EMPTY;
            endcase
            credit_ret[i] = (state[i] == EX) && wb_done[i];
        end
    end

    // ages stay a dense rank over occupied rows
    // a freed row pulls older ones down, a dispatch pushes all up
    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            age_nxt[i] = age[i];
            if (state[i] != EMPTY) begin
                for (int k = 0; k < NUM_FU; k++) begin
                    if (credit_ret[k] && age[i] > age[k]) begin
                        age_nxt[i] = age_nxt[i] - 2'd1;
                    end
                end
                if (disp_en && age_nxt[i] != '1) begin
                    age_nxt[i] = age_nxt[i] + 2'd1;
                end
            end
            if (disp_en && disp_fu == fu_idx_t'(i)) begin
                age_nxt[i] = age_t'(1);
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_FU; i++) begin
                state[i] <= EMPTY;
                age[i]   <= '0;
            end
        end else begin
            state <= state_nxt;
            age   <= age_nxt;
        end
    end

    a_iss_onehot: assert property (@(posedge CLK) disable iff (!nRST) $onehot0(iss_en));

    for (genvar i = 0; i < NUM_FU; i++) begin : g_row_chk
        // issued from WAIT or RDY, then held in EX
        a_iss_state: assert property (@(posedge CLK) disable iff (!nRST)
            iss_en[i] |-> (state[i] == WAIT || state[i] == RDY) ##1 state[i] == EX);
        // execute only finishes a unit whose row is in EX
        a_done_ex: assert property (@(posedge CLK) disable iff (!nRST)
            wb_done[i] |-> state[i] == EX);
    end

endmodule

`default_nettype wire

/* hw/execute.sv */
// execute stage: ALU, multiplier and load/store unit over a small data memory,
// sharing one write-back port through a fixed-priority arbiter
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic            CLK,
    input  logic            nRST,
    input  sb_pkg::fu_vec_t iss_en,
    input  sb_pkg::opcode_t iss_op,
    input  sb_pkg::reg_t    iss_rd,
    input  sb_pkg::word_t   iss_a,
    input  sb_pkg::word_t   iss_b,
    input  sb_pkg::imm_t    iss_imm,
    output sb_pkg::fu_vec_t wb_done,
    output logic            wb_en,
    output sb_pkg::reg_t    wb_reg,
    output sb_pkg::word_t   wb_data
);

    import sb_pkg::*;

    // imm is zero-extended
    word_t imm_ext;
    word_t eff_addr;
    // alu, result register only
    logic  alu_full;
    reg_t  alu_rd;
    word_t alu_res;
    // multiplier, countdown to zero then hold
    logic  mul_busy;
    logic  [1:0] mul_cnt;
    reg_t  mul_rd;
    word_t mul_res;
    // load/store
    logic  mem_busy;
    logic  [1:0] mem_cnt;
    reg_t  mem_rd;
    logic  mem_st;
    logic  [MEM_AW-1:0] mem_addr;
    word_t mem_wdata;
    word_t mem [MEM_WORDS];
    fu_vec_t fin;
    fu_vec_t grant;
    fu_vec_t busy;

    always_comb begin
        imm_ext  = word_t'(iss_imm);
        eff_addr = iss_a + imm_ext;
        busy[FU_ALU] = alu_full;
        busy[FU_MUL] = mul_busy;
        busy[FU_MEM] = mem_busy;
        fin[FU_ALU]  = alu_full;
        fin[FU_MUL]  = mul_busy && mul_cnt == '0;
        fin[FU_MEM]  = mem_busy && mem_cnt == '0;
        // ALU over MUL over MEM
        grant = '0;
        if (fin[FU_ALU]) begin
            grant[FU_ALU] = 1'b1;
        end else if (fin[FU_MUL]) begin
            grant[FU_MUL] = 1'b1;
        end else if (fin[FU_MEM]) begin
            grant[FU_MEM] = 1'b1;
        end
        wb_done = grant;
        wb_en   = grant[FU_ALU] || grant[FU_MUL] || (grant[FU_MEM] && !mem_st);
        wb_reg  = alu_rd;
        wb_data = alu_res;
        if (grant[FU_MUL]) begin
            wb_reg  = mul_rd;
            wb_data = mul_res;
        end else if (grant[FU_MEM]) begin
            wb_reg  = mem_rd;
            wb_data = mem[mem_addr];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            alu_full <= 1'b0;
            mul_busy <= 1'b0;
            mul_cnt  <= '0;
            mem_busy <= 1'b0;
            mem_cnt  <= '0;
        end else begin
            if (iss_en[FU_ALU]) begin
                alu_full <= 1'b1;
            end else if (grant[FU_ALU]) begin
                alu_full <= 1'b0;
            end
            if (iss_en[FU_MUL]) begin
                mul_busy <= 1'b1;
                mul_cnt  <= 2'(MUL_LAT - 1);
            end else if (grant[FU_MUL]) begin
                mul_busy <= 1'b0;
            end else if (mul_cnt != '0) begin
                mul_cnt <= mul_cnt - 2'd1;
            end
            if (iss_en[FU_MEM]) begin
                mem_busy <= 1'b1;
                mem_cnt  <= 2'(MEM_LAT - 1);
            end else if (grant[FU_MEM]) begin
                mem_busy <= 1'b0;
            end else if (mem_cnt != '0) begin
                mem_cnt <= mem_cnt - 2'd1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (iss_en[FU_ALU]) begin
            alu_rd  <= iss_rd;
            alu_res <= iss_a + iss_b + imm_ext;
        end
        if (iss_en[FU_MUL]) begin
            mul_rd  <= iss_rd;
            mul_res <= iss_a * iss_b;
        end
        if (iss_en[FU_MEM]) begin
            mem_rd    <= iss_rd;
            mem_st    <= (iss_op == OP_ST);
            mem_addr  <= eff_addr[MEM_AW-1:0];
            mem_wdata <= iss_b;
        end
    end

    // store commits only when it wins the port
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (grant[FU_MEM] && mem_st) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // issue keeps a row in EX until its unit is granted
    a_unit_free: assert property (@(posedge CLK) disable iff (!nRST)
        (iss_en & busy) == '0);

endmodule

`default_nettype wire

/* hw/sb_top.sv */
// scoreboard core top, joins dispatch, issue and execute
// instructions enter by valid/ready, results leave on the write-back port
`timescale 1ns/1ps
`default_nettype none

module sb_top (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            in_valid,
    input  sb_pkg::instr_t  in_instr,
    output logic            in_ready,
    output logic            wb_en,
    output sb_pkg::reg_t    wb_reg,
    output sb_pkg::word_t   wb_data,
    output sb_pkg::fu_vec_t wb_done
);

    import sb_pkg::*;

    // dispatch to issue
    logic    disp_en;
    fu_idx_t disp_fu;
    opcode_t disp_op;
    reg_t    disp_rd;
    reg_t    disp_rs1;
    reg_t    disp_rs2;
    imm_t    disp_imm;
    tag_t    disp_t1;
    tag_t    disp_t2;
    fu_vec_t credit_ret;
    // issue to execute
    fu_vec_t iss_en;
    opcode_t iss_op;
    reg_t    iss_rd;
    word_t   iss_a;
    word_t   iss_b;
    imm_t    iss_imm;

    dispatch i_dispatch (
        .CLK, .nRST, .in_valid, .in_instr, .in_ready,
        .disp_en, .disp_fu, .disp_op, .disp_rd, .disp_rs1, .disp_rs2,
        .disp_imm, .disp_t1, .disp_t2, .credit_ret, .wb_done
    );

    issue i_issue (
        .CLK, .nRST,
        .disp_en, .disp_fu, .disp_op, .disp_rd, .disp_rs1, .disp_rs2,
        .disp_imm, .disp_t1, .disp_t2, .credit_ret,
        .wb_done, .wb_en, .wb_reg, .wb_data,
        .iss_en, .iss_op, .iss_rd, .iss_a, .iss_b, .iss_imm
    );

    execute i_execute (
        .CLK, .nRST, .iss_en, .iss_op, .iss_rd, .iss_a, .iss_b, .iss_imm,
        .wb_done, .wb_en, .wb_reg, .wb_data
    );

endmodule

`default_nettype wire

/* test/tb_sb_tasks.svh */
// directed tests, handshake, reference model and instruction encoding
// included inside the tb_sb module body, uses its signals and counters
`ifndef TB_SB_TASKS_SVH
`define TB_SB_TASKS_SVH

    // op, rd, rs1, rs2, imm from high to low bits
    function automatic instr_t encode(input opcode_t op, input reg_t rd, input reg_t rs1,
                                      input reg_t rs2, input imm_t imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    // sequential semantics of one accepted word
    function automatic void model_accept(input instr_t w);
        opcode_t    op;
        reg_t       rd;
        reg_t       rs1;
        reg_t       rs2;
        imm_t       imm;
        word_t      res;
        logic [3:0] addr;
        op   = opcode_t'(w[15:14]);
        rd   = w[13:11];
        rs1  = w[10:8];
        rs2  = w[7:5];
        imm  = w[4:0];
        addr = 4'((shadow_reg[rs1] + word_t'(imm)) % MEM_WORDS);
        case (op)
            OP_ADD:  res = shadow_reg[rs1] + shadow_reg[rs2] + word_t'(imm);
            // low half of the product
            OP_MUL:  res = shadow_reg[rs1] * shadow_reg[rs2];
            OP_LD:   res = shadow_mem[addr];
            default: res = '0;
        endcase
        if (op == OP_ST) begin
            shadow_mem[addr] = shadow_reg[rs2];
        end else begin
            shadow_reg[rd] = res;
            exp_q[rd].push_back(res);
        end
        accepted++;
    endfunction

    function automatic void check_writeback(input reg_t r, input word_t d);
        word_t expected;
        if (exp_q[r].size() == 0) begin
            errors++;
            $display("write-back to r%0d at %0t with no result pending for it", r, $time);
        end else begin
            expected = exp_q[r].pop_front();
            if (d != expected) begin
                errors++;
                $display("Error at %0t: wb_data for r%0d expected %h, got %h",
                         $time, r, expected, d);
            end
        end
    endfunction

    // called after a falling edge, returns after a falling edge with in_valid low
    task automatic send_instr(input instr_t w);
        int   waited;
        logic taken;
        waited   = 0;
        taken    = 1'b0;
        in_valid = 1'b1;
        in_instr = w;
        while (!taken && waited < STALL_LIMIT) begin
            // in_ready has settled a quarter period after the falling edge
            #(CLK_PERIOD / 4);
            if (in_ready) begin
                taken = 1'b1;
                model_accept(w);
            end else begin
                waited++;
            end
            @(negedge CLK);
        end
        in_valid = 1'b0;
        if (!taken) begin
            errors++;
            $display("in_ready stayed low for %0d cycles, word %h not accepted", waited, w);
        end
    endtask

    // wait until every accepted word has reported done
    task automatic drain();
        int waited;
        waited = 0;
        while (done_seen < accepted && waited < DRAIN_LIMIT) begin
            @(negedge CLK);
            waited++;
        end
        if (done_seen < accepted) begin
            errors++;
            $display("drain timed out, %0d words accepted but %0d finished",
                     accepted, done_seen);
        end
        // room for any extra write-back to show up
        repeat (3) @(negedge CLK);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic idle_after_reset();
        int errs_before;
        errs_before = errors;
        for (int c = 0; c < 8; c++) begin
            @(negedge CLK);
            if (in_ready !== 1'b1) begin
                errors++;
                $display("Error at %0t: in_ready expected 1, got %b", $time, in_ready);
            end
            if (wb_en !== 1'b0) begin
                errors++;
                $display("Error at %0t: wb_en expected 0, got %b", $time, wb_en);
            end
            if (wb_done !== '0) begin
                errors++;
                $display("Error at %0t: wb_done expected 000, got %b", $time, wb_done);
            end
        end
        report_test("idle_after_reset", errs_before);
    endtask

    task automatic raw_chain();
        int errs_before;
        errs_before = errors;
        send_instr(encode(OP_ADD, 3'd1, 3'd0, 3'd0, 5'd5));
        send_instr(encode(OP_ADD, 3'd2, 3'd0, 3'd0, 5'd9));
        send_instr(encode(OP_ADD, 3'd3, 3'd1, 3'd2, 5'd1));
        send_instr(encode(OP_ADD, 3'd4, 3'd3, 3'd1, 5'd0));
        // r1 again, held back until its first writer is done
        send_instr(encode(OP_ADD, 3'd1, 3'd4, 3'd3, 5'd2));
        send_instr(encode(OP_ADD, 3'd5, 3'd1, 3'd1, 5'd31));
        drain();
        report_test("raw_chain", errs_before);
    endtask

    task automatic mul_then_adds();
        int errs_before;
        errs_before = errors;
        send_instr(encode(OP_MUL, 3'd6, 3'd3, 3'd4, 5'd0));
        send_instr(encode(OP_ADD, 3'd1, 3'd2, 3'd2, 5'd3));
        send_instr(encode(OP_ADD, 3'd2, 3'd0, 3'd1, 5'd7));
        // waits on the product
        send_instr(encode(OP_ADD, 3'd7, 3'd6, 3'd2, 5'd0));
        drain();
        report_test("mul_then_adds", errs_before);
    endtask

    task automatic store_then_loads();
        int errs_before;
        errs_before = errors;
        send_instr(encode(OP_ADD, 3'd2, 3'd0, 3'd0, 5'd29));
        // address 19 wraps to word 3
        send_instr(encode(OP_ST, 3'd0, 3'd0, 3'd2, 5'd19));
        send_instr(encode(OP_LD, 3'd3, 3'd0, 3'd0, 5'd3));
        send_instr(encode(OP_LD, 3'd4, 3'd0, 3'd0, 5'd9));
        drain();
        report_test("store_then_loads", errs_before);
    endtask

    // older store reads r3 behind a MUL, younger ADD overwrites r3
    task automatic war_on_mul();
        int errs_before;
        errs_before = errors;
        send_instr(encode(OP_MUL, 3'd5, 3'd1, 3'd2, 5'd0));
        send_instr(encode(OP_ST, 3'd0, 3'd5, 3'd3, 5'd4));
        send_instr(encode(OP_ADD, 3'd3, 3'd0, 3'd0, 5'd11));
        // reads back what the store saw in r3
        send_instr(encode(OP_LD, 3'd7, 3'd5, 3'd0, 5'd4));
        drain();
        report_test("war_on_mul", errs_before);
    endtask

    task automatic random_stream();
        int errs_before;
        errs_before = errors;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            repeat ($urandom_range(2, 0)) @(negedge CLK);
            send_instr(instr_t'($urandom()));
        end
        drain();
        report_test("random_stream", errs_before);
    endtask

    task automatic final_checks();
        for (int r = 0; r < NUM_REGS; r++) begin
            if (exp_q[r].size() != 0) begin
                errors++;
                $display("r%0d still waits for %0d write-backs", r, exp_q[r].size());
            end
        end
        if (accepted != done_seen) begin
            errors++;
            $display("%0d words accepted but %0d done pulses seen", accepted, done_seen);
        end
    endtask

`endif

/* test/tb_sb.sv */
// testbench top for the scoreboard core, with clock, reset, reference model and watchdog
// runs the directed tests from the included task file and prints the verdict
`timescale 1ns/1ps
`default_nettype none

module tb_sb;

    import sb_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 2;
    localparam int NUM_DIRECTED    = 18;
    localparam int NUM_RANDOM      = 200;
    localparam int WATCHDOG_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 20;
    // per-handshake and per-drain limits, both well under the watchdog
    localparam int STALL_LIMIT     = 60;
    localparam int DRAIN_LIMIT     = 100;
    localparam logic [31:0] SEED   = 32'h3c4b_742b;

    logic    CLK;
    logic    nRST;
    logic    in_valid;
    instr_t  in_instr;
    logic    in_ready;
    logic    wb_en;
    reg_t    wb_reg;
    word_t   wb_data;
    fu_vec_t wb_done;

    // shadow state, updated in program order at each accepted word
    word_t shadow_reg [NUM_REGS];
    word_t shadow_mem [MEM_WORDS];
    // expected results per destination register, oldest first
    word_t exp_q [NUM_REGS][$];

    int errors;
    int tests_run;
    int tests_failed;
    int accepted;
    int done_seen;

    sb_top i_dut (
        .CLK,
        .nRST,
        .in_valid,
        .in_instr,
        .in_ready,
        .wb_en,
        .wb_reg,
        .wb_data,
        .wb_done
    );

    `include "tb_sb_tasks.svh"

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // write-back monitor, mid-cycle where the execute outputs are steady
    always @(negedge CLK) begin
        if (nRST) begin
            done_seen += $countones(wb_done);
            if (wb_en) begin
                check_writeback(wb_reg, wb_data);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        nRST         = 1'b0;
        in_valid     = 1'b0;
        in_instr     = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        accepted     = 0;
        done_seen    = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            shadow_reg[r] = '0;
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            shadow_mem[w] = '0;
        end
        // reset released on a falling edge
        repeat (RESET_CYCLES) @(negedge CLK);
        nRST = 1'b1;

        idle_after_reset();
        raw_chain();
        mul_then_adds();
        store_then_loads();
        war_on_mul();
        random_stream();

        final_checks();
        $display("tests run %0d, failed %0d, errors %0d, instructions %0d",
                 tests_run, tests_failed, errors, accepted);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+test
hw/sb_pkg.sv
hw/regfile.sv
hw/fust.sv
hw/dispatch.sv
hw/issue.sv
hw/execute.sv
hw/sb_top.sv
test/tb_sb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
